// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // ----------------------------------------------------------------------
    // Cache geometry
    // ----------------------------------------------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int byte_bits  = 2;
    localparam int word_bits  = 2;
    localparam int index_bits = 3;
    localparam int tag_bits   = addr_width - index_bits - word_bits - byte_bits;
    localparam int line_words = 1 << word_bits;

    // Top address byte of the cached region
    localparam logic [7:0] cacheable_region = 8'ha0;

    // AXI field encodings used by the miss burst and local responses
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [2:0] axi_size_word  = 3'b010;
    localparam logic [1:0] axi_resp_okay  = 2'b00;

    // Controller state codes
    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_bypass    = 3'd1;
    localparam logic [2:0] st_lookup    = 3'd2;
    localparam logic [2:0] st_miss_addr = 3'd3;
    localparam logic [2:0] st_miss_fill = 3'd4;
    localparam logic [2:0] st_respond   = 3'd5;

    // One fetch address, split for the cache or for region decode
    typedef union packed {
        struct packed {
            logic [tag_bits-1:0]   tag;
            logic [index_bits-1:0] index;
            logic [word_bits-1:0]  word;
            logic [byte_bits-1:0]  byte_off;
        } cache_view;
        struct packed {
            logic [7:0]  region;
            logic [23:0] rest;
        } region_view;
    } fetch_addr_t;

endpackage

`default_nettype wire

// ==== src/icache_array.sv ====
`default_nettype none

module icache_array (
    input  logic                                clock,
    input  logic                                reset,
    input  icache_pkg::fetch_addr_t             lookup_addr,
    output logic                                hit,
    input  logic                                alloc,
    input  logic                                fill_valid,
    input  logic [icache_pkg::word_bits-1:0]    fill_word,
    input  logic [icache_pkg::data_width-1:0]   fill_data,
    output logic [icache_pkg::data_width-1:0]   read_data
);

    localparam int num_lines = 1 << icache_pkg::index_bits;
    localparam int num_words = num_lines * icache_pkg::line_words;

    logic [icache_pkg::tag_bits-1:0]   tag_mem  [num_lines];
    logic [icache_pkg::data_width-1:0] data_mem [num_words];
    logic [num_lines-1:0]              valid_bits;

    logic [icache_pkg::index_bits-1:0] index;
    logic [icache_pkg::tag_bits-1:0]   tag;
    logic [icache_pkg::index_bits+icache_pkg::word_bits-1:0] read_slot;
    logic [icache_pkg::index_bits+icache_pkg::word_bits-1:0] fill_slot;

    assign index = lookup_addr.cache_view.index;
    assign tag   = lookup_addr.cache_view.tag;

    // Word slot inside the flat data store
    assign read_slot = {index, lookup_addr.cache_view.word};
    assign fill_slot = {index, fill_word};

    // ----------------------------------------------------------------------
    // Lookup
    // ----------------------------------------------------------------------
    assign hit       = valid_bits[index] && (tag_mem[index] == tag);
    assign read_data = data_mem[read_slot];

    // ----------------------------------------------------------------------
    // Allocation and fill
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (alloc) begin
            valid_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            tag_mem[index] <= tag;
        end
        // One beat of the line burst per strobe
        if (fill_valid) begin
            data_mem[fill_slot] <= fill_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl (
    input  logic                                clock,
    input  logic                                reset,
    // Fetch side
    input  logic                                s_arvalid,
    output logic                                s_arready,
    input  logic [icache_pkg::addr_width-1:0]   s_araddr,
    input  logic [3:0]                          s_arid,
    input  logic [7:0]                          s_arlen,
    input  logic [2:0]                          s_arsize,
    input  logic [1:0]                          s_arburst,
    output logic                                s_rvalid,
    input  logic                                s_rready,
    output logic [icache_pkg::data_width-1:0]   s_rdata,
    output logic [1:0]                          s_rresp,
    output logic                                s_rlast,
    output logic [3:0]                          s_rid,
    // Memory side
    output logic                                m_arvalid,
    input  logic                                m_arready,
    output logic [icache_pkg::addr_width-1:0]   m_araddr,
    output logic [3:0]                          m_arid,
    output logic [7:0]                          m_arlen,
    output logic [2:0]                          m_arsize,
    output logic [1:0]                          m_arburst,
    input  logic                                m_rvalid,
    output logic                                m_rready,
    input  logic [icache_pkg::data_width-1:0]   m_rdata,
    input  logic [1:0]                          m_rresp,
    input  logic                                m_rlast,
    input  logic [3:0]                          m_rid,
    // Array
    output icache_pkg::fetch_addr_t             lookup_addr,
    input  logic                                hit,
    output logic                                alloc,
    output logic                                fill_valid,
    output logic [icache_pkg::word_bits-1:0]    fill_word,
    output logic [icache_pkg::data_width-1:0]   fill_data,
    input  logic [icache_pkg::data_width-1:0]   read_data,
    // Event pulses
    output logic                                hit_event,
    output logic                                miss_event,
    output logic                                bypass_event
);

    logic [2:0]                          state;
    logic [icache_pkg::word_bits-1:0]    fill_cnt;
    icache_pkg::fetch_addr_t             in_addr;
    icache_pkg::fetch_addr_t             req_addr;
    logic [3:0]                          req_id;
    logic                                bypass_sel;
    logic                                ar_xfer;

    assign in_addr    = s_araddr;
    assign bypass_sel = s_arvalid &&
                        (in_addr.region_view.region != icache_pkg::cacheable_region);
    assign ar_xfer    = (state == icache_pkg::st_idle) && s_arvalid && s_arready;

    // ----------------------------------------------------------------------
    // State register and fill counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= icache_pkg::st_idle;
            fill_cnt <= '0;
        end else begin
            case (state)
                icache_pkg::st_idle: begin
                    // Route fixed here for the whole transaction
                    if (ar_xfer) begin
                        state <= bypass_sel ? icache_pkg::st_bypass : icache_pkg::st_lookup;
                    end
                end
                icache_pkg::st_bypass: begin
                    if (m_rvalid && s_rready && m_rlast) begin
                        state <= icache_pkg::st_idle;
                    end
                end
                icache_pkg::st_lookup: begin
                    fill_cnt <= '0;
                    state    <= hit ? icache_pkg::st_respond : icache_pkg::st_miss_addr;
                end
                icache_pkg::st_miss_addr: begin
                    if (m_arready) begin
                        state <= icache_pkg::st_miss_fill;
                    end
                end
                icache_pkg::st_miss_fill: begin
                    if (m_rvalid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (m_rlast) begin
                            state <= icache_pkg::st_respond;
                        end
                    end
                end
                icache_pkg::st_respond: begin
                    if (s_rready) begin
                        state <= icache_pkg::st_idle;
                    end
                end
                default: state <= icache_pkg::st_idle;
            endcase
        end
    end

    // Request capture
    always_ff @(posedge clock) begin
        if (ar_xfer) begin
            req_addr <= in_addr;
            req_id   <= s_arid;
        end
    end

    // ----------------------------------------------------------------------
    // Array side
    // ----------------------------------------------------------------------
    assign lookup_addr = req_addr;
    assign alloc       = (state == icache_pkg::st_lookup) && !hit;
    assign fill_valid  = (state == icache_pkg::st_miss_fill) && m_rvalid;
    assign fill_word   = fill_cnt;
    assign fill_data   = m_rdata;

    assign hit_event    = (state == icache_pkg::st_lookup) && hit;
    assign miss_event   = alloc;
    assign bypass_event = ar_xfer && bypass_sel;

    // ----------------------------------------------------------------------
    // AR channels
    // ----------------------------------------------------------------------
    always_comb begin
        s_arready = 1'b0;
        m_arvalid = 1'b0;
        // Line-aligned refill burst by default
        m_araddr  = {req_addr.cache_view.tag, req_addr.cache_view.index,
                     {(icache_pkg::word_bits + icache_pkg::byte_bits){1'b0}}};
        m_arid    = req_id;
        m_arlen   = 8'(icache_pkg::line_words - 1);
        m_arsize  = icache_pkg::axi_size_word;
        m_arburst = icache_pkg::axi_burst_incr;
        if (state == icache_pkg::st_idle) begin
            s_arready = bypass_sel ? m_arready : 1'b1;
            if (bypass_sel) begin
                m_arvalid = s_arvalid;
                m_araddr  = s_araddr;
                m_arid    = s_arid;
                m_arlen   = s_arlen;
                m_arsize  = s_arsize;
                m_arburst = s_arburst;
            end
        end else if (state == icache_pkg::st_miss_addr) begin
            m_arvalid = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // R channels
    // ----------------------------------------------------------------------
    always_comb begin
        s_rvalid = (state == icache_pkg::st_respond);
        s_rdata  = read_data;
        s_rresp  = icache_pkg::axi_resp_okay;
        s_rlast  = 1'b1;
        s_rid    = req_id;
        m_rready = (state == icache_pkg::st_miss_fill);
        if (state == icache_pkg::st_bypass) begin
            s_rvalid = m_rvalid;
            s_rdata  = m_rdata;
            s_rresp  = m_rresp;
            s_rlast  = m_rlast;
            s_rid    = m_rid;
            m_rready = s_rready;
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_perf.sv ====
`default_nettype none

module icache_perf (
    input  logic        clock,
    input  logic        reset,
    input  logic        hit_event,
    input  logic        miss_event,
    input  logic        bypass_event,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count,
    output logic [31:0] bypass_count
);

    // ----------------------------------------------------------------------
    // Event counters, free running and wrapping
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count    <= '0;
            miss_count   <= '0;
            bypass_count <= '0;
        end else begin
            if (hit_event) begin
                hit_count <= hit_count + 32'd1;
            end
            if (miss_event) begin
                miss_count <= miss_count + 32'd1;
            end
            // Uncached traffic kept apart from cache effectiveness
            if (bypass_event) begin
                bypass_count <= bypass_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`default_nettype none

module icache_top (
    input  logic                                clock,
    input  logic                                reset,
    // Fetch side
    input  logic                                s_arvalid,
    output logic                                s_arready,
    input  logic [icache_pkg::addr_width-1:0]   s_araddr,
    input  logic [3:0]                          s_arid,
    input  logic [7:0]                          s_arlen,
    input  logic [2:0]                          s_arsize,
    input  logic [1:0]                          s_arburst,
    output logic                                s_rvalid,
    input  logic                                s_rready,
    output logic [icache_pkg::data_width-1:0]   s_rdata,
    output logic [1:0]                          s_rresp,
    output logic                                s_rlast,
    output logic [3:0]                          s_rid,
    // Memory side
    output logic                                m_arvalid,
    input  logic                                m_arready,
    output logic [icache_pkg::addr_width-1:0]   m_araddr,
    output logic [3:0]                          m_arid,
    output logic [7:0]                          m_arlen,
    output logic [2:0]                          m_arsize,
    output logic [1:0]                          m_arburst,
    input  logic                                m_rvalid,
    output logic                                m_rready,
    input  logic [icache_pkg::data_width-1:0]   m_rdata,
    input  logic [1:0]                          m_rresp,
    input  logic                                m_rlast,
    input  logic [3:0]                          m_rid,
    // Profiling
    output logic [31:0]                         hit_count,
    output logic [31:0]                         miss_count,
    output logic [31:0]                         bypass_count
);

    // Controller to array
    icache_pkg::fetch_addr_t              lookup_addr;
    logic                                 hit;
    logic                                 alloc;
    logic                                 fill_valid;
    logic [icache_pkg::word_bits-1:0]     fill_word;
    logic [icache_pkg::data_width-1:0]    fill_data;
    logic [icache_pkg::data_width-1:0]    read_data;

    // Controller to counters
    logic                                 hit_event;
    logic                                 miss_event;
    logic                                 bypass_event;

    // Port names match the wires above
    icache_ctrl icache_ctrl_inst (.*);

    icache_array icache_array_inst (.*);

    icache_perf icache_perf_inst (.*);

endmodule

`default_nettype wire

// ==== dv/icache_asserts.sv ====
`default_nettype none

module icache_asserts (
    input logic        clock,
    input logic        reset,
    input logic        s_arvalid,
    input logic        s_arready,
    input logic        s_rvalid,
    input logic        s_rready,
    input logic [31:0] s_rdata,
    input logic        m_arvalid,
    input logic        m_arready,
    input logic [31:0] m_araddr,
    input logic [7:0]  m_arlen,
    input logic        m_rvalid,
    input logic        m_rready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int failures;

    initial failures = 0;

    // ----------------------------------------------------------------------
    // Valid held until its transfer
    // ----------------------------------------------------------------------
    s_ar_hold: assert property (@(posedge clock) disable iff (reset)
        s_arvalid && !s_arready |=> s_arvalid)
        else begin
            failures++;
            $error("s_arvalid dropped before its transfer");
        end

    m_ar_hold: assert property (@(posedge clock) disable iff (reset)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else begin
            failures++;
            $error("m_arvalid or m_araddr changed before the transfer");
        end

    s_r_hold: assert property (@(posedge clock) disable iff (reset)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else begin
            failures++;
            $error("s_rvalid or s_rdata changed before the transfer");
        end

    m_r_hold: assert property (@(posedge clock) disable iff (reset)
        m_rvalid && !m_rready |=> m_rvalid)
        else begin
            failures++;
            $error("m_rvalid dropped before its transfer");
        end

    // Cacheable reads on the memory side are line refills only
    refill_len: assert property (@(posedge clock) disable iff (reset)
        m_arvalid && m_araddr[31:24] == icache_pkg::cacheable_region |-> m_arlen == 8'd3)
        else begin
            failures++;
            $error("line refill with m_arlen %0d", m_arlen);
        end

    quiet_in_reset: assert property (@(posedge clock) reset |-> !s_rvalid)
        else begin
            failures++;
            $error("s_rvalid high during reset");
        end

endmodule

`default_nettype wire

// ==== dv/axi_mem_model.sv ====
`default_nettype none

module axi_mem_model (
    input  logic        clock,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [3:0]  arid,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] lfsr;
    logic [31:0] addr;
    logic [31:0] step;
    logic [7:0]  len;
    logic [3:0]  id;
    int          gap;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Delay of 0 to 3 cycles before a beat
    task automatic draw_gap(output int value);
        value = 0;
        repeat (2) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    initial begin
        lfsr    = 32'h5f85;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        rlast   = 1'b0;
        rid     = '0;
        @(negedge clock);
        forever begin
            // One burst at a time, AR accepted only while idle
            arready = 1'b1;
            #1;
            if (arvalid) begin
                addr = araddr;
                len  = arlen;
                id   = arid;
                step = 32'd1 << arsize;
                @(negedge clock);
                arready = 1'b0;
                for (int beat = 0; beat <= int'(len); beat++) begin
                    draw_gap(gap);
                    repeat (gap) @(negedge clock);
                    rvalid = 1'b1;
                    rdata  = {addr[31:2], 2'b00} ^ 32'h1234_5678;
                    rresp  = 2'b00;
                    rlast  = (beat == int'(len));
                    rid    = id;
                    #1;
                    while (!rready) begin
                        @(negedge clock);
                        #1;
                    end
                    @(negedge clock);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                    addr   = addr + step;
                end
            end else begin
                @(negedge clock);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/icache_tb.sv ====
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {kind_hit, kind_miss, kind_bypass} kind_t;

    typedef struct {
        logic [31:0] addr;
        logic [7:0]  len;
        kind_t       kind;
        logic        stall;
    } entry_t;

    localparam int num_entries = 13;
    localparam int cycle_limit = 400 * num_entries;
    localparam logic [31:0] data_mask = 32'h1234_5678;

    logic        clock;
    logic        reset;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_araddr;
    logic [3:0]  s_arid;
    logic [7:0]  s_arlen;
    logic [2:0]  s_arsize;
    logic [1:0]  s_arburst;
    logic        s_rvalid;
    logic        s_rready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rlast;
    logic [3:0]  s_rid;
    logic        m_arvalid;
    logic        m_arready;
    logic [31:0] m_araddr;
    logic [3:0]  m_arid;
    logic [7:0]  m_arlen;
    logic [2:0]  m_arsize;
    logic [1:0]  m_arburst;
    logic        m_rvalid;
    logic        m_rready;
    logic [31:0] m_rdata;
    logic [1:0]  m_rresp;
    logic        m_rlast;
    logic [3:0]  m_rid;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic [31:0] bypass_count;

    entry_t      entries [num_entries];
    logic [31:0] lfsr;
    int          cycle;
    int          error_count;
    int          check_count;
    int          m_ar_count;
    int          m_r_count;
    logic [31:0] m_ar_addr_seen;
    logic [7:0]  m_ar_len_seen;
    logic [2:0]  m_ar_size_seen;
    logic [1:0]  m_ar_burst_seen;

    icache_top icache_top_inst (.*);

    axi_mem_model mem_model_inst (
        .clock   (clock),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .araddr  (m_araddr),
        .arid    (m_arid),
        .arlen   (m_arlen),
        .arsize  (m_arsize),
        .rvalid  (m_rvalid),
        .rready  (m_rready),
        .rdata   (m_rdata),
        .rresp   (m_rresp),
        .rlast   (m_rlast),
        .rid     (m_rid)
    );

    bind icache_top icache_asserts icache_asserts_inst (
        .clock     (clock),
        .reset     (reset),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_rdata   (s_rdata),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Stall length of 0 to 3 extra cycles
    task automatic draw_stall(output int value);
        value = 0;
        repeat (2) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    task automatic check_that(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("** Error at %0d ns: %s", $time, what);
        end
    endtask

    task automatic load_table();
        // Index 1 conflicts between 0x10 and 0x90 lines
        entries[0]  = '{32'ha000_0010, 8'd0, kind_miss,   1'b0};
        entries[1]  = '{32'ha000_0018, 8'd0, kind_hit,    1'b0};
        entries[2]  = '{32'ha000_001c, 8'd0, kind_hit,    1'b1};
        entries[3]  = '{32'ha000_0094, 8'd0, kind_miss,   1'b0};
        entries[4]  = '{32'ha000_0090, 8'd0, kind_hit,    1'b0};
        entries[5]  = '{32'ha000_0014, 8'd0, kind_miss,   1'b1};
        entries[6]  = '{32'h1000_0040, 8'd3, kind_bypass, 1'b0};
        entries[7]  = '{32'h1000_0100, 8'd3, kind_bypass, 1'b1};
        entries[8]  = '{32'ha000_0014, 8'd0, kind_hit,    1'b0};
        entries[9]  = '{32'ha000_0ff8, 8'd0, kind_miss,   1'b1};
        entries[10] = '{32'ha000_0ff0, 8'd0, kind_hit,    1'b0};
        entries[11] = '{32'h2000_0000, 8'd0, kind_bypass, 1'b1};
        entries[12] = '{32'ha000_0094, 8'd0, kind_miss,   1'b0};
    endtask

    // One request, all of its beats, then the memory-side traffic
    task automatic run_entry(input int n);
        entry_t      e;
        int          ar_before;
        int          r_before;
        int          ar_cycle;
        int          gap;
        logic [31:0] word_addr;
        logic [31:0] held_data;
        logic        held_last;
        e = entries[n];
        ar_before = m_ar_count;
        r_before  = m_r_count;
        s_arvalid = 1'b1;
        s_araddr  = e.addr;
        s_arid    = 4'(n);
        s_arlen   = e.len;
        s_arsize  = 3'd2;
        s_arburst = 2'b01;
        #1;
        while (!s_arready) begin
            @(negedge clock);
            #1;
        end
        ar_cycle = cycle;
        @(negedge clock);
        s_arvalid = 1'b0;
        for (int beat = 0; beat <= int'(e.len); beat++) begin
            s_rready = !e.stall;
            #1;
            while (!s_rvalid) begin
                @(negedge clock);
                #1;
            end
            if (beat == 0 && e.kind == kind_hit) begin
                check_that(cycle - ar_cycle == 2,
                    $sformatf("hit at %h answered after %0d cycles", e.addr, cycle - ar_cycle));
            end
            if (e.stall) begin
                held_data = s_rdata;
                held_last = s_rlast;
                draw_stall(gap);
                repeat (gap + 1) begin
                    @(negedge clock);
                    #1;
                    check_that(s_rvalid && s_rdata == held_data && s_rlast == held_last,
                        $sformatf("entry %0d beat %0d changed while stalled", n, beat));
                end
                @(negedge clock);
                s_rready = 1'b1;
                #1;
            end
            word_addr = {e.addr[31:2], 2'b00} + 32'(beat * 4);
            check_that(s_rdata == (word_addr ^ data_mask),
                $sformatf("entry %0d beat %0d data %h, expected %h",
                          n, beat, s_rdata, word_addr ^ data_mask));
            check_that(s_rresp == 2'b00 && s_rid == 4'(n) && s_rlast == (beat == int'(e.len)),
                $sformatf("entry %0d beat %0d resp %0d id %0d last %0d",
                          n, beat, s_rresp, s_rid, s_rlast));
            @(negedge clock);
        end
        s_rready = 1'b0;
        case (e.kind)
            kind_hit: check_that(m_ar_count == ar_before,
                $sformatf("hit at %h issued a memory read", e.addr));
            kind_miss: check_that(m_ar_count == ar_before + 1 && m_r_count == r_before + 4 &&
                                  m_ar_len_seen == 8'd3 && m_ar_size_seen == 3'd2 &&
                                  m_ar_burst_seen == 2'b01 &&
                                  m_ar_addr_seen == {e.addr[31:4], 4'h0},
                $sformatf("miss at %h gave a wrong line burst", e.addr));
            default: check_that(m_ar_count == ar_before + 1 && m_ar_addr_seen == e.addr &&
                                m_r_count == r_before + int'(e.len) + 1,
                $sformatf("bypass at %h not passed through", e.addr));
        endcase
    endtask

    // ----------------------------------------------------------------------
    // Clock, memory-side monitor and watchdog
    // ----------------------------------------------------------------------
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        m_ar_count = 0;
        m_r_count  = 0;
        forever begin
            @(negedge clock);
            #2;
            if (m_arvalid && m_arready) begin
                m_ar_count++;
                m_ar_addr_seen  = m_araddr;
                m_ar_len_seen   = m_arlen;
                m_ar_size_seen  = m_arsize;
                m_ar_burst_seen = m_arburst;
            end
            if (m_rvalid && m_rready) begin
                m_r_count++;
            end
        end
    end

    initial begin
        cycle = 0;
        while (cycle < cycle_limit) begin
            @(posedge clock);
            cycle++;
        end
        $display("Timeout: no finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int hits;
        int misses;
        int bypasses;
        int assert_failures;
        reset       = 1'b1;
        s_arvalid   = 1'b0;
        s_araddr    = '0;
        s_arid      = '0;
        s_arlen     = '0;
        s_arsize    = '0;
        s_arburst   = '0;
        s_rready    = 1'b0;
        lfsr        = 32'h5f85;
        error_count = 0;
        check_count = 0;
        hits        = 0;
        misses      = 0;
        bypasses    = 0;
        load_table();
        repeat (3) @(negedge clock);
        reset = 1'b0;
        #1;
        check_that(s_arready && !s_rvalid && !m_arvalid && !m_rready,
            "handshake outputs wrong after reset");
        check_that(hit_count == 0 && miss_count == 0 && bypass_count == 0,
            "counters not cleared by reset");
        @(negedge clock);
        for (int n = 0; n < num_entries; n++) begin
            run_entry(n);
            if (entries[n].kind == kind_hit) hits++;
            else if (entries[n].kind == kind_miss) misses++;
            else bypasses++;
        end
        repeat (2) @(negedge clock);
        check_that(hit_count == 32'(hits) && miss_count == 32'(misses) &&
                   bypass_count == 32'(bypasses),
            $sformatf("counters %0d/%0d/%0d, expected %0d/%0d/%0d", hit_count,
                      miss_count, bypass_count, hits, misses, bypasses));
        assert_failures = icache_top_inst.icache_asserts_inst.failures;
        $display("Done: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/icache_pkg.sv
src/icache_array.sv
src/icache_ctrl.sv
src/icache_perf.sv
src/icache_top.sv
dv/icache_asserts.sv
dv/axi_mem_model.sv
dv/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
